//--- src/soc_bus_pkg.sv
package soc_bus_pkg;

    // Request from the CPU-side master.
    typedef struct packed {
        logic [31:0] address;
        logic [3:0]  byteenable;
        logic        read;
        logic        write;
        logic [31:0] wrdata;
    } master_req_t;

    // Response to the master.
    typedef struct packed {
        logic [31:0] rddata;
        logic        stall;
    } master_rsp_t;

    // Request as seen by one slave.
    typedef struct packed {
        logic [23:0] address;
        logic [3:0]  byteenable;
        logic [31:0] wrdata;
        logic        rd;
        logic        wr;
    } dev_req_t;

    // Response from one slave.
    typedef struct packed {
        logic [31:0] rddata;
        logic        stall;
    } dev_rsp_t;

    // Address windows.
    localparam logic [7:0]  RAM_SEGMENT = 8'h00;
    localparam logic [23:0] GPIO_PAGE   = 24'h1fd004;
    localparam logic [23:0] TICKER_PAGE = 24'h1fd005;

    // Register offsets within a page.
    localparam logic [7:0] GPIO_OUT_OFS   = 8'h00;
    localparam logic [7:0] GPIO_IN_OFS    = 8'h04;
    localparam logic [7:0] TICK_COUNT_OFS = 8'h00;
    localparam logic [7:0] TICK_CMP_OFS   = 8'h04;
    localparam logic [7:0] TICK_FLAG_OFS  = 8'h08;

    // Replace the enabled bytes of a word.
    function automatic logic [31:0] be_merge(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  be
    );
        logic [31:0] merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- src/dbus.sv
module dbus (
    input  soc_bus_pkg::master_req_t master_req_i,
    output soc_bus_pkg::master_rsp_t master_rsp_o,
    output soc_bus_pkg::dev_req_t    ram_req_o,
    output soc_bus_pkg::dev_req_t    gpio_req_o,
    output soc_bus_pkg::dev_req_t    ticker_req_o,
    input  soc_bus_pkg::dev_rsp_t    ram_rsp_i,
    input  soc_bus_pkg::dev_rsp_t    gpio_rsp_i,
    input  soc_bus_pkg::dev_rsp_t    ticker_rsp_i
);

    soc_bus_pkg::dev_req_t shared_req;
    logic                  ram_sel;
    logic                  gpio_sel;
    logic                  ticker_sel;
    logic [2:0]            strobes;

    // Window decode.
    assign ram_sel    = (master_req_i.address[31:24] == soc_bus_pkg::RAM_SEGMENT);
    assign gpio_sel   = (master_req_i.address[31:8] == soc_bus_pkg::GPIO_PAGE);
    assign ticker_sel = (master_req_i.address[31:8] == soc_bus_pkg::TICKER_PAGE);

    // Fields common to every slave; strobes stay low here.
    always_comb begin
        shared_req.address    = master_req_i.address[23:0];
        shared_req.byteenable = master_req_i.byteenable;
        shared_req.wrdata     = master_req_i.wrdata;
        shared_req.rd         = 1'b0;
        shared_req.wr         = 1'b0;
    end

    always_comb begin
        ram_req_o           = shared_req;
        gpio_req_o          = shared_req;
        ticker_req_o        = shared_req;
        // Each strobe from its own window match.
        ram_req_o.rd        = ram_sel & master_req_i.read;
        ram_req_o.wr        = ram_sel & master_req_i.write;
        gpio_req_o.rd       = gpio_sel & master_req_i.read;
        gpio_req_o.wr       = gpio_sel & master_req_i.write;
        ticker_req_o.rd     = ticker_sel & master_req_i.read;
        ticker_req_o.wr     = ticker_sel & master_req_i.write;
        master_rsp_o.rddata = 32'h0;
        master_rsp_o.stall  = 1'b0;
        if (ram_sel) begin
            master_rsp_o.rddata = ram_rsp_i.rddata;
            master_rsp_o.stall  = ram_rsp_i.stall;
        end else if (gpio_sel) begin
            master_rsp_o.rddata = gpio_rsp_i.rddata;
            master_rsp_o.stall  = gpio_rsp_i.stall;
        end else if (ticker_sel) begin
            master_rsp_o.rddata = ticker_rsp_i.rddata;
            master_rsp_o.stall  = ticker_rsp_i.stall;
        end
        // Unmapped: reads zero, no stall, writes dropped.
    end

    assign strobes = {ram_req_o.rd | ram_req_o.wr,
                      gpio_req_o.rd | gpio_req_o.wr,
                      ticker_req_o.rd | ticker_req_o.wr};

    // At most one slave strobe high.
    always_comb begin
        a_one_slave : assert final ($onehot0(strobes))
            else $error("dbus: more than one slave strobe active");
    end

endmodule

//--- src/bus_ram.sv
module bus_ram #(
    parameter int RAM_WORDS_LOG2 = 8,
    parameter int RAM_WAIT       = 2
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  soc_bus_pkg::dev_req_t req_i,
    output soc_bus_pkg::dev_rsp_t rsp_o
);

    localparam int               CNT_W     = $clog2(RAM_WAIT + 1);
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(RAM_WAIT);

    logic [31:0]               mem [2**RAM_WORDS_LOG2];
    logic [CNT_W-1:0]          wait_cnt_q;
    logic [RAM_WORDS_LOG2-1:0] word_idx;
    logic                      active;
    logic                      done;

    // Word index from the bits above the byte lane.
    assign word_idx = req_i.address[RAM_WORDS_LOG2+1:2];
    assign active   = req_i.rd | req_i.wr;
    assign done     = active && (wait_cnt_q == WAIT_LAST);

    // Wait-state counter, restarts after each completion.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wait_cnt_q <= '0;
        end else if (!active || done) begin
            wait_cnt_q <= '0;
        end else begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (done && req_i.wr) begin
            mem[word_idx] <= soc_bus_pkg::be_merge(mem[word_idx], req_i.wrdata,
                                                   req_i.byteenable);
        end
    end

    assign rsp_o.rddata = (done && req_i.rd) ? mem[word_idx] : 32'h0;
    assign rsp_o.stall  = active && !done;

    // Master must hold its request while stalled.
    property p_hold_on_stall;
        @(posedge clk_i) disable iff (reset_i)
        rsp_o.stall |=> $stable(req_i);
    endproperty

    a_hold_on_stall : assert property (p_hold_on_stall)
        else $error("bus_ram: request changed during stall");

endmodule

//--- src/gpio_regs.sv
module gpio_regs (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  soc_bus_pkg::dev_req_t req_i,
    output soc_bus_pkg::dev_rsp_t rsp_o,
    input  logic [31:0]           gpio_in_i,
    output logic [31:0]           gpio_out_o
);

    logic [31:0] out_q;
    logic [7:0]  offset;
    logic [31:0] rd_word;

    assign offset = req_i.address[7:0];

    // Output register, byte-wise writes.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_q <= 32'h0;
        end else if (req_i.wr && (offset == soc_bus_pkg::GPIO_OUT_OFS)) begin
            out_q <= soc_bus_pkg::be_merge(out_q, req_i.wrdata, req_i.byteenable);
        end
    end

    always_comb begin
        rd_word = 32'h0;
        if (req_i.rd) begin
            case (offset)
                soc_bus_pkg::GPIO_OUT_OFS: rd_word = out_q;
                soc_bus_pkg::GPIO_IN_OFS:  rd_word = gpio_in_i;
                default:                   rd_word = 32'h0;
            endcase
        end
    end

    assign rsp_o.rddata = rd_word;
    assign rsp_o.stall  = 1'b0;
    assign gpio_out_o   = out_q;

endmodule

//--- src/ticker.sv
module ticker (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  soc_bus_pkg::dev_req_t req_i,
    output soc_bus_pkg::dev_rsp_t rsp_o,
    output logic                  irq_o
);

    logic [31:0] count_q;
    logic [31:0] cmp_q;
    logic        flag_q;
    logic        match;
    logic [7:0]  offset;
    logic [31:0] rd_word;

    assign offset = req_i.address[7:0];
    assign match  = (count_q == cmp_q);

    // Free-running count.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= 32'h0;
        end else begin
            count_q <= count_q + 32'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmp_q <= 32'hffff_ffff;
        end else if (req_i.wr && (offset == soc_bus_pkg::TICK_CMP_OFS)) begin
            cmp_q <= soc_bus_pkg::be_merge(cmp_q, req_i.wrdata, req_i.byteenable);
        end
    end

    // Sticky flag; a fresh match beats a clear.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            flag_q <= 1'b0;
        end else if (match) begin
            flag_q <= 1'b1;
        end else if (req_i.wr && (offset == soc_bus_pkg::TICK_FLAG_OFS)) begin
            flag_q <= 1'b0;
        end
    end

    always_comb begin
        rd_word = 32'h0;
        if (req_i.rd) begin
            case (offset)
                soc_bus_pkg::TICK_COUNT_OFS: rd_word = count_q;
                soc_bus_pkg::TICK_CMP_OFS:   rd_word = cmp_q;
                soc_bus_pkg::TICK_FLAG_OFS:  rd_word = {31'h0, flag_q};
                default:                     rd_word = 32'h0;
            endcase
        end
    end

    assign rsp_o.rddata = rd_word;
    assign rsp_o.stall  = 1'b0;
    assign irq_o        = flag_q;

    a_irq_after_match : assert property (
        @(posedge clk_i) disable iff (reset_i)
        $rose(irq_o) |-> $past(match)
    ) else $error("ticker: irq rose without a preceding match");

endmodule

//--- src/dbus_top.sv
module dbus_top #(
    parameter int RAM_WORDS_LOG2 = 8,
    parameter int RAM_WAIT       = 2
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  soc_bus_pkg::master_req_t master_req_i,
    output soc_bus_pkg::master_rsp_t master_rsp_o,
    input  logic [31:0]              gpio_in_i,
    output logic [31:0]              gpio_out_o,
    output logic                     irq_o
);

    soc_bus_pkg::dev_req_t ram_req;
    soc_bus_pkg::dev_req_t gpio_req;
    soc_bus_pkg::dev_req_t ticker_req;
    soc_bus_pkg::dev_rsp_t ram_rsp;
    soc_bus_pkg::dev_rsp_t gpio_rsp;
    soc_bus_pkg::dev_rsp_t ticker_rsp;

    // Address decoder.
    dbus u_dbus (
        .master_req_i (master_req_i),
        .master_rsp_o (master_rsp_o),
        .ram_req_o    (ram_req),
        .gpio_req_o   (gpio_req),
        .ticker_req_o (ticker_req),
        .ram_rsp_i    (ram_rsp),
        .gpio_rsp_i   (gpio_rsp),
        .ticker_rsp_i (ticker_rsp)
    );

    bus_ram #(
        .RAM_WORDS_LOG2 (RAM_WORDS_LOG2),
        .RAM_WAIT       (RAM_WAIT)
    ) u_bus_ram (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (ram_req),
        .rsp_o   (ram_rsp)
    );

    gpio_regs u_gpio_regs (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (gpio_req),
        .rsp_o      (gpio_rsp),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o)
    );

    // Timer with compare interrupt.
    ticker u_ticker (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (ticker_req),
        .rsp_o   (ticker_rsp),
        .irq_o   (irq_o)
    );

endmodule

//--- sim/tb_dbus_checks.svh
// One bus transfer; starts and ends a short delay after a rising edge.
task automatic bus_access(
    input  logic [31:0]              addr,
    input  logic [3:0]               be,
    input  logic                     is_write,
    input  logic [31:0]              data,
    output soc_bus_pkg::master_rsp_t rsp,
    output int                       stall_cycles
);
    master_req.address    = addr;
    master_req.byteenable = be;
    master_req.wrdata     = data;
    master_req.read       = !is_write;
    master_req.write      = is_write;
    stall_cycles          = 0;
    // Sample mid-cycle, once the response has settled.
    @(negedge clk);
    while (master_rsp.stall && stall_cycles < ACCESS_TIMEOUT) begin
        stall_cycles++;
        @(negedge clk);
    end
    if (master_rsp.stall) begin
        $display("Access to %h timed out, stall still high after %0d cycles",
                 addr, stall_cycles);
        error_count++;
    end
    rsp = master_rsp;
    @(posedge clk);
    #1;
    master_req.read  = 1'b0;
    master_req.write = 1'b0;
endtask

task automatic bus_write(
    input  logic [31:0] addr,
    input  logic [3:0]  be,
    input  logic [31:0] data,
    output int          stall_cycles
);
    soc_bus_pkg::master_rsp_t rsp;
    bus_access(addr, be, 1'b1, data, rsp, stall_cycles);
endtask

task automatic bus_read(
    input  logic [31:0]              addr,
    output soc_bus_pkg::master_rsp_t rsp,
    output int                       stall_cycles
);
    bus_access(addr, 4'hf, 1'b0, 32'h0, rsp, stall_cycles);
endtask

task automatic check_rsp(
    input string                    name,
    input soc_bus_pkg::master_rsp_t expected,
    input soc_bus_pkg::master_rsp_t actual
);
    check_count++;
    if (actual !== expected) begin
        $display("CHECK FAILED %s: expected rddata=%h stall=%b, actual rddata=%h stall=%b",
                 name, expected.rddata, expected.stall, actual.rddata, actual.stall);
        error_count++;
    end
endtask

task automatic check_gpio(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        $display("CHECK FAILED %s: expected gpio_out=%h, actual gpio_out=%h",
                 name, expected, actual);
        error_count++;
    end
endtask

task automatic check_cycles(input string name, input int expected, input int actual);
    check_count++;
    if (actual != expected) begin
        $display("CHECK FAILED %s: expected %0d stall cycles, actual %0d",
                 name, expected, actual);
        error_count++;
    end
endtask

task automatic check_level(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        $display("CHECK FAILED %s: expected irq=%b, actual irq=%b", name, expected, actual);
        error_count++;
    end
endtask

//--- sim/tb_dbus_top.sv
module tb_dbus_top;

    localparam int          EXP_RAM_WAIT    = 2;
    localparam int          ACCESS_TIMEOUT  = 20;
    localparam int          IRQ_TIMEOUT     = 40;
    localparam logic [31:0] GPIO_OUT_ADDR   = 32'h1fd0_0400;
    localparam logic [31:0] GPIO_IN_ADDR    = 32'h1fd0_0404;
    localparam logic [31:0] TICK_COUNT_ADDR = 32'h1fd0_0500;
    localparam logic [31:0] TICK_CMP_ADDR   = 32'h1fd0_0504;
    localparam logic [31:0] TICK_FLAG_ADDR  = 32'h1fd0_0508;
    localparam logic [31:0] UNMAPPED_ADDR   = 32'h1c00_0000;

    logic                     clk = 1'b0;
    logic                     reset;
    soc_bus_pkg::master_req_t master_req;
    soc_bus_pkg::master_rsp_t master_rsp;
    logic [31:0]              gpio_in;
    logic [31:0]              gpio_out;
    logic                     irq;

    logic [31:0] ram_model [256];
    logic [31:0] gpio_model;
    integer      seed;
    int          error_count;
    int          check_count;
    int          tests_run;

    always #20 clk = ~clk;

    dbus_top u_dut (
        .clk_i        (clk),
        .reset_i      (reset),
        .master_req_i (master_req),
        .master_rsp_o (master_rsp),
        .gpio_in_i    (gpio_in),
        .gpio_out_o   (gpio_out),
        .irq_o        (irq)
    );

    `include "tb_dbus_checks.svh"

    // Expected word after a masked write.
    function automatic logic [31:0] merge_masked(input logic [31:0] old_word,
                                                 input logic [31:0] new_word,
                                                 input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic soc_bus_pkg::master_rsp_t completed_rsp(input logic [31:0] data);
        soc_bus_pkg::master_rsp_t rsp;
        rsp.rddata = data;
        rsp.stall  = 1'b0;
        return rsp;
    endfunction

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (error_count == start_errors) begin
            $display("Test %s passed", name);
        end else begin
            $display("Test %s failed with %0d errors", name, error_count - start_errors);
        end
    endtask

    task automatic test_ram_write_read();
        string                    name;
        logic [31:0]              addrs [$];
        logic [31:0]              addr;
        logic [31:0]              data;
        soc_bus_pkg::master_rsp_t rsp;
        int                       stalls;
        int                       start_errors;
        name         = "ram_write_read";
        start_errors = error_count;
        for (int i = 0; i < 8; i++) begin
            addr = $random(seed) & 32'h0000_03fc;
            data = $random(seed);
            bus_write(addr, 4'hf, data, stalls);
            check_cycles(name, EXP_RAM_WAIT, stalls);
            ram_model[addr[9:2]] = data;
            addrs.push_back(addr);
        end
        foreach (addrs[i]) begin
            bus_read(addrs[i], rsp, stalls);
            check_cycles(name, EXP_RAM_WAIT, stalls);
            check_rsp(name, completed_rsp(ram_model[addrs[i][9:2]]), rsp);
        end
        finish_test(name, start_errors);
    endtask

    task automatic test_ram_byte_enables();
        string                    name;
        logic [31:0]              addr;
        logic [31:0]              data;
        soc_bus_pkg::master_rsp_t rsp;
        int                       stalls;
        int                       start_errors;
        name         = "ram_byte_enables";
        start_errors = error_count;
        addr         = 32'h0000_0100;
        bus_write(addr, 4'hf, 32'hffff_ffff, stalls);
        ram_model[addr[9:2]] = 32'hffff_ffff;
        data = $random(seed);
        bus_write(addr, 4'b0110, data, stalls);
        ram_model[addr[9:2]] = merge_masked(ram_model[addr[9:2]], data, 4'b0110);
        bus_read(addr, rsp, stalls);
        check_rsp(name, completed_rsp(ram_model[addr[9:2]]), rsp);
        finish_test(name, start_errors);
    endtask

    task automatic test_gpio();
        string                    name;
        logic [31:0]              data;
        soc_bus_pkg::master_rsp_t rsp;
        int                       stalls;
        int                       start_errors;
        name         = "gpio";
        start_errors = error_count;
        bus_write(GPIO_OUT_ADDR, 4'hf, 32'h1234_5678, stalls);
        gpio_model = 32'h1234_5678;
        check_cycles(name, 0, stalls);
        check_gpio(name, gpio_model, gpio_out);
        data = $random(seed);
        bus_write(GPIO_OUT_ADDR, 4'b1001, data, stalls);
        gpio_model = merge_masked(gpio_model, data, 4'b1001);
        check_cycles(name, 0, stalls);
        check_gpio(name, gpio_model, gpio_out);
        gpio_in = $random(seed);
        bus_read(GPIO_IN_ADDR, rsp, stalls);
        check_cycles(name, 0, stalls);
        check_rsp(name, completed_rsp(gpio_in), rsp);
        bus_read(GPIO_OUT_ADDR, rsp, stalls);
        check_cycles(name, 0, stalls);
        check_rsp(name, completed_rsp(gpio_model), rsp);
        finish_test(name, start_errors);
    endtask

    task automatic test_unmapped();
        string                    name;
        soc_bus_pkg::master_rsp_t rsp;
        int                       stalls;
        int                       start_errors;
        name         = "unmapped";
        start_errors = error_count;
        // Word 0 is what a bad decode would hit.
        bus_write(32'h0000_0000, 4'hf, 32'ha5a5_5a5a, stalls);
        ram_model[0] = 32'ha5a5_5a5a;
        bus_read(UNMAPPED_ADDR, rsp, stalls);
        check_cycles(name, 0, stalls);
        check_rsp(name, completed_rsp(32'h0), rsp);
        bus_write(UNMAPPED_ADDR, 4'hf, $random(seed), stalls);
        check_cycles(name, 0, stalls);
        check_gpio(name, gpio_model, gpio_out);
        bus_read(32'h0000_0000, rsp, stalls);
        check_rsp(name, completed_rsp(ram_model[0]), rsp);
        finish_test(name, start_errors);
    endtask

    task automatic test_ticker();
        string                    name;
        soc_bus_pkg::master_rsp_t rsp;
        logic [31:0]              first_count;
        logic [31:0]              second_count;
        int                       stalls;
        int                       waited;
        int                       start_errors;
        name         = "ticker";
        start_errors = error_count;
        bus_read(TICK_COUNT_ADDR, rsp, stalls);
        first_count = rsp.rddata;
        bus_read(TICK_COUNT_ADDR, rsp, stalls);
        second_count = rsp.rddata;
        check_count++;
        if (second_count <= first_count) begin
            $display("Ticker count did not increase, read %h then %h",
                     first_count, second_count);
            error_count++;
        end
        check_level(name, 1'b0, irq);
        bus_write(TICK_CMP_ADDR, 4'hf, second_count + 32'd20, stalls);
        waited = 0;
        @(negedge clk);
        while (!irq && waited < IRQ_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!irq) begin
            $display("Ticker irq did not rise within %0d cycles of the compare write",
                     IRQ_TIMEOUT);
            error_count++;
        end
        @(posedge clk);
        #1;
        bus_read(TICK_FLAG_ADDR, rsp, stalls);
        check_rsp(name, completed_rsp(32'h1), rsp);
        bus_write(TICK_FLAG_ADDR, 4'hf, $random(seed), stalls);
        check_level(name, 1'b0, irq);
        bus_read(TICK_FLAG_ADDR, rsp, stalls);
        check_rsp(name, completed_rsp(32'h0), rsp);
        finish_test(name, start_errors);
    endtask

    initial begin
        seed        = 32'ha9f28ec8;
        error_count = 0;
        check_count = 0;
        tests_run   = 0;
        reset       = 1'b1;
        master_req  = '0;
        gpio_in     = 32'h0;
        gpio_model  = 32'h0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_gpio("reset", 32'h0, gpio_out);
        check_level("reset", 1'b0, irq);
        test_ram_write_read();
        test_ram_byte_enables();
        test_gpio();
        test_unmapped();
        test_ticker();
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+sim
src/soc_bus_pkg.sv
src/dbus.sv
src/bus_ram.sv
src/gpio_regs.sv
src/ticker.sv
src/dbus_top.sv
sim/tb_dbus_top.sv
